//--- hdl/lcd_pkg.sv
package lcd_pkg;

	// display setup word, msb first
	typedef struct packed {
		logic two_lines;  // N bit of function set
		logic font_5x10;  // F bit
		logic display_on;
		logic cursor_on;
		logic blink_on;
		logic increment;  // I/D bit of entry mode
		logic shift;      // S bit
	} lcd_cfg_t;

	// text writer opcodes
	typedef enum logic [1:0] {
		OP_CHAR,
		OP_CLEAR,
		OP_HOME
	} lcd_op_e;

	localparam logic [7:0] CMD_CLEAR     = 8'h01;
	localparam logic [7:0] CMD_HOME      = 8'h02;
	localparam logic [7:0] CMD_SET_DDRAM = 8'h80; // or-ed with the 7-bit address
	localparam logic [6:0] LINE2_ADDR    = 7'h40;
	localparam int         LINE_LEN      = 16;    // characters per line

	// delays in microseconds
	localparam int T_POWER_US = 500; // power-up settle
	localparam int T_SHORT_US = 50;  // most commands
	localparam int T_CLEAR_US = 200; // clear display

	// enable pulse shape for one bus transfer
	localparam int T_EHIGH_US = 13;
	localparam int T_ELOW_US  = 13;
	localparam int T_XFER_US  = 50;  // whole transfer slot

	typedef enum logic [1:0] {
		ST_POWER,
		ST_INIT,
		ST_IDLE,
		ST_XFER
	} ctrl_state_e;

endpackage

//--- hdl/lcd_bus_if.sv
`timescale 1ns/1ns

interface lcd_bus_if;

	logic       req;  // one-cycle strobe
	logic       rs;   // 0 command, 1 data
	logic       rw;
	logic [7:0] data;
	logic       busy; // controller still working on a transfer

	modport writer (
		output req,
		output rs,
		output rw,
		output data,
		input  busy
	);

	modport ctrl (
		input  req,
		input  rs,
		input  rw,
		input  data,
		output busy
	);

endinterface

//--- hdl/lcd_ctrl.sv
`timescale 1ns/1ns

module lcd_ctrl
	import lcd_pkg::*;
#(
	parameter int CLK_PER_US = 35
) (
	input  logic       clk,
	input  logic       rst,
	input  lcd_cfg_t   cfg,
	lcd_bus_if.ctrl    bus,
	output logic       e,
	output logic       rs,
	output logic       rw,
	output logic [7:0] lcd_data
);

	localparam int E_CMD_US = 10; // enable high time of an init command

	// init schedule in microseconds, each command is a pulse then its wait
	localparam int ONOFF_US = E_CMD_US + T_SHORT_US;
	localparam int CLR_US   = ONOFF_US + E_CMD_US + T_SHORT_US;
	localparam int ENTRY_US = CLR_US + E_CMD_US + T_CLEAR_US;
	localparam int DONE_US  = ENTRY_US + E_CMD_US + 2 * T_SHORT_US;

	localparam int CNT_W = $clog2(T_POWER_US * CLK_PER_US + 1); // power wait is the longest

	localparam logic [CNT_W-1:0] PWR_LAST    = CNT_W'(T_POWER_US * CLK_PER_US - 1);
	localparam logic [CNT_W-1:0] FUNC_END    = CNT_W'(E_CMD_US * CLK_PER_US);
	localparam logic [CNT_W-1:0] ONOFF_BEG   = CNT_W'(ONOFF_US * CLK_PER_US);
	localparam logic [CNT_W-1:0] ONOFF_END   = CNT_W'((ONOFF_US + E_CMD_US) * CLK_PER_US);
	localparam logic [CNT_W-1:0] CLR_BEG     = CNT_W'(CLR_US * CLK_PER_US);
	localparam logic [CNT_W-1:0] CLR_END     = CNT_W'((CLR_US + E_CMD_US) * CLK_PER_US);
	localparam logic [CNT_W-1:0] ENTRY_BEG   = CNT_W'(ENTRY_US * CLK_PER_US);
	localparam logic [CNT_W-1:0] ENTRY_END   = CNT_W'((ENTRY_US + E_CMD_US) * CLK_PER_US);
	localparam logic [CNT_W-1:0] INIT_LAST   = CNT_W'(DONE_US * CLK_PER_US - 1);

	// transfer slot, counter starts one cycle after req and e is registered
	localparam logic [CNT_W-1:0] E_RISE    = CNT_W'(CLK_PER_US - 1);
	localparam logic [CNT_W-1:0] E_FALL    = CNT_W'((1 + T_EHIGH_US) * CLK_PER_US - 1);
	localparam logic [CNT_W-1:0] XFER_LAST = CNT_W'(T_XFER_US * CLK_PER_US - 2);

	if (CLK_PER_US < 1 || 1 + T_EHIGH_US + T_ELOW_US > T_XFER_US) begin : g_bad_timing
		$error("lcd_ctrl: enable pulse does not fit in the transfer slot");
	end

	ctrl_state_e      state;
	logic [CNT_W-1:0] cnt;
	logic             init_e;
	logic [7:0]       init_data;

	// init pulse windows, data only present while e is high
	always_comb begin
		init_e    = 1'b0;
		init_data = 8'h00;
		if (cnt < FUNC_END) begin
			init_e    = 1'b1;
			init_data = {4'b0011, cfg.two_lines, cfg.font_5x10, 2'b00};
		end else if (cnt >= ONOFF_BEG && cnt < ONOFF_END) begin
			init_e    = 1'b1;
			init_data = {5'b00001, cfg.display_on, cfg.cursor_on, cfg.blink_on};
		end else if (cnt >= CLR_BEG && cnt < CLR_END) begin
			init_e    = 1'b1;
			init_data = CMD_CLEAR;
		end else if (cnt >= ENTRY_BEG && cnt < ENTRY_END) begin
			init_e    = 1'b1;
			init_data = {6'b000001, cfg.increment, cfg.shift};
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state    <= ST_POWER;
			cnt      <= '0;
			bus.busy <= 1'b1; // busy through power-up and init
			e        <= 1'b0;
			rs       <= 1'b0;
			rw       <= 1'b0;
			lcd_data <= 8'h00;
		end else begin
			case (state)
				ST_POWER: begin
					if (cnt == PWR_LAST) begin
						state <= ST_INIT;
						cnt   <= '0;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				ST_INIT: begin
					e        <= init_e;
					lcd_data <= init_data;
					if (cnt == INIT_LAST) begin
						state    <= ST_IDLE;
						cnt      <= '0;
						bus.busy <= 1'b0;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				ST_IDLE: begin
					if (bus.req) begin
						state    <= ST_XFER;
						rs       <= bus.rs; // pins valid from next cycle
						rw       <= bus.rw;
						lcd_data <= bus.data;
						bus.busy <= 1'b1;
					end
				end
				ST_XFER: begin
					e <= (cnt >= E_RISE) && (cnt < E_FALL);
					if (cnt == XFER_LAST) begin
						state    <= ST_IDLE;
						cnt      <= '0;
						bus.busy <= 1'b0; // low exactly one slot after req
						rs       <= 1'b0;
						rw       <= 1'b0;
						lcd_data <= 8'h00;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: state <= ST_POWER;
			endcase
		end
	end

	// the writer must never strobe into a running transfer
	a_req_not_busy: assert property (@(posedge clk) disable iff (rst)
		bus.req |-> !bus.busy)
		else $error("lcd_ctrl: req while busy");

	a_no_e_idle: assert property (@(posedge clk) disable iff (rst)
		state == ST_IDLE |-> !e)
		else $error("lcd_ctrl: e high in idle");

endmodule

//--- hdl/lcd_text_writer.sv
`timescale 1ns/1ns

module lcd_text_writer
	import lcd_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       op_valid,
	input  lcd_op_e    op,
	input  logic [7:0] op_char,
	output logic       busy,
	lcd_bus_if.writer  bus
);

	localparam logic [3:0] LAST_COL = 4'(LINE_LEN - 1);

	logic       line;      // 0 first line, 1 second
	logic [3:0] col;
	logic       pend;      // address command still to send
	logic       op_known;
	logic       op_fire;
	logic       pend_fire;
	logic [6:0] wrap_addr;

	assign busy      = pend | bus.busy;
	assign op_known  = (op == OP_CHAR) || (op == OP_CLEAR) || (op == OP_HOME);
	assign op_fire   = op_valid & op_known & ~busy;
	assign pend_fire = pend & ~bus.busy; // first free cycle after the char
	assign wrap_addr = line ? LINE2_ADDR : 7'h00; // line already moved on

	assign bus.req = op_fire | pend_fire;
	assign bus.rw  = 1'b0; // write only

	always_comb begin
		bus.rs   = 1'b0;
		bus.data = CMD_SET_DDRAM | {1'b0, wrap_addr};
		if (!pend) begin
			case (op)
				OP_CHAR: begin
					bus.rs   = 1'b1;
					bus.data = op_char;
				end
				OP_CLEAR: bus.data = CMD_CLEAR;
				OP_HOME:  bus.data = CMD_HOME;
				default:  bus.data = 8'h00;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			line <= 1'b0;
			col  <= 4'd0;
			pend <= 1'b0;
		end else begin
			if (pend_fire) begin
				pend <= 1'b0;
			end
			if (op_fire) begin
				case (op)
					OP_CHAR: begin
						if (col == LAST_COL) begin // line full, jump to the other one
							col  <= 4'd0;
							line <= ~line;
							pend <= 1'b1;
						end else begin
							col <= col + 4'd1;
						end
					end
					OP_CLEAR, OP_HOME: begin
						line <= 1'b0;
						col  <= 4'd0;
					end
					default: ;
				endcase
			end
		end
	end

	a_op_not_busy: assert property (@(posedge clk) disable iff (rst)
		op_valid |-> !busy)
		else $error("lcd_text_writer: op_valid while busy");

endmodule

//--- hdl/lcd_top.sv
`timescale 1ns/1ns

module lcd_top
	import lcd_pkg::*;
#(
	parameter int CLK_PER_US = 35
) (
	input  logic       clk,
	input  logic       rst,
	input  lcd_cfg_t   cfg,
	input  logic       op_valid,
	input  lcd_op_e    op,
	input  logic [7:0] op_char,
	output logic       e,
	output logic       rs,
	output logic       rw,
	output logic [7:0] lcd_data,
	output logic       busy
);

	lcd_bus_if u_bus ();

	// busy here already covers the controller
	lcd_text_writer u_writer (
		.clk      (clk),
		.rst      (rst),
		.op_valid (op_valid),
		.op       (op),
		.op_char  (op_char),
		.busy     (busy),
		.bus      (u_bus.writer)
	);

	lcd_ctrl #(
		.CLK_PER_US (CLK_PER_US)
	) u_ctrl (
		.clk      (clk),
		.rst      (rst),
		.cfg      (cfg),
		.bus      (u_bus.ctrl),
		.e        (e),
		.rs       (rs),
		.rw       (rw),
		.lcd_data (lcd_data)
	);

endmodule

//--- dv/lcd_clk_gen.sv
`timescale 1ns/1ns

module lcd_clk_gen #(
	parameter int PERIOD_NS  = 8,
	parameter int RST_CYCLES = 10
) (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	initial begin
		rst = 1'b1;
		repeat (RST_CYCLES) @(posedge clk);
		rst <= 1'b0; // released on a rising edge
	end

endmodule

//--- dv/lcd_bus_mon.sv
`timescale 1ns/1ns

module lcd_bus_mon (
	input  logic        clk,
	input  logic        rst,
	input  logic        e,
	input  logic        rs,
	input  logic        rw,
	input  logic [7:0]  lcd_data,
	output logic        got,        // one cycle after e falls
	output logic        got_rs,
	output logic        got_rw,
	output logic [7:0]  got_data,
	output logic [15:0] got_width,  // cycles e was high
	output logic        got_stable  // pins held through the pulse
);

	logic [15:0] high_cnt;
	logic        cap_rs;
	logic        cap_rw;
	logic [7:0]  cap_data;
	logic        steady;

	always_ff @(posedge clk) begin
		if (rst) begin
			high_cnt   <= '0;
			steady     <= 1'b1;
			got        <= 1'b0;
			got_rs     <= 1'b0;
			got_rw     <= 1'b0;
			got_data   <= 8'h00;
			got_width  <= '0;
			got_stable <= 1'b0;
		end else begin
			got <= 1'b0;
			if (e) begin
				high_cnt <= high_cnt + 16'd1;
				if (high_cnt == 16'd0) begin // first high cycle
					cap_rs   <= rs;
					cap_rw   <= rw;
					cap_data <= lcd_data;
					steady   <= 1'b1;
				end else if (rs != cap_rs || rw != cap_rw || lcd_data != cap_data) begin
					steady <= 1'b0;
				end
			end else if (high_cnt != 16'd0) begin // e just fell
				got        <= 1'b1;
				got_rs     <= cap_rs;
				got_rw     <= cap_rw;
				got_data   <= cap_data;
				got_width  <= high_cnt;
				got_stable <= steady;
				high_cnt   <= '0;
			end
		end
	end

endmodule

//--- dv/lcd_tb.sv
`timescale 1ns/1ns

module lcd_tb
	import lcd_pkg::*;
();

	localparam int U           = 2;  // clock cycles per microsecond
	localparam int N_OPS       = 60;
	localparam int E_CMD_US    = 10; // init command enable time
	localparam int POWER_CYC   = T_POWER_US * U;
	localparam int INIT_US     = T_POWER_US + 4 * E_CMD_US + 4 * T_SHORT_US + T_CLEAR_US;
	localparam int TIMEOUT_CYC = 2 * (INIT_US * U + N_OPS * 2 * T_XFER_US * U);

	logic        clk;
	logic        rst;
	lcd_cfg_t    cfg;
	logic        op_valid;
	lcd_op_e     op;
	logic [7:0]  op_char;
	logic        e;
	logic        rs;
	logic        rw;
	logic [7:0]  lcd_data;
	logic        busy;

	logic        got;
	logic        got_rs;
	logic        got_rw;
	logic [7:0]  got_data;
	logic [15:0] got_width;
	logic        got_stable;

	logic [8:0]  exp_q[$];  // {rs, data} in bus order
	logic [8:0]  exp_x;
	int          exp_w;
	int          n_got = 0;
	int          line_fill; // chars written on the current line
	logic        on_line2;
	integer      seed;
	logic [31:0] rnd;
	int unsigned cycles = 0;
	int unsigned init_start; // cycle count at reset release
	int          pick;
	int          gap;

	lcd_clk_gen #(.PERIOD_NS(8), .RST_CYCLES(10)) u_clk_gen (.clk(clk), .rst(rst));

	lcd_top #(.CLK_PER_US(U)) u_lcd_top (
		.clk      (clk),
		.rst      (rst),
		.cfg      (cfg),
		.op_valid (op_valid),
		.op       (op),
		.op_char  (op_char),
		.e        (e),
		.rs       (rs),
		.rw       (rw),
		.lcd_data (lcd_data),
		.busy     (busy)
	);

	lcd_bus_mon u_bus_mon (
		.clk        (clk),
		.rst        (rst),
		.e          (e),
		.rs         (rs),
		.rw         (rw),
		.lcd_data   (lcd_data),
		.got        (got),
		.got_rs     (got_rs),
		.got_rw     (got_rw),
		.got_data   (got_data),
		.got_width  (got_width),
		.got_stable (got_stable)
	);

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TEST FAIL");
		$fatal(1);
	endtask

	task automatic value_mismatch(input string name, input logic [31:0] got_v,
			input logic [31:0] exp_v);
		abort_run($sformatf("Fail at %0t ns: %s = %0h, expected %0h", $time, name, got_v, exp_v));
	endtask

	// HD44780 init commands built from the setup word
	task automatic queue_init_cmds();
		exp_q.push_back({1'b0, 4'b0011, cfg.two_lines, cfg.font_5x10, 2'b00});
		exp_q.push_back({1'b0, 5'b00001, cfg.display_on, cfg.cursor_on, cfg.blink_on});
		exp_q.push_back({1'b0, CMD_CLEAR});
		exp_q.push_back({1'b0, 6'b000001, cfg.increment, cfg.shift});
	endtask

	task automatic issue_op(input lcd_op_e kind, input logic [7:0] ch);
		int n_xfer;   // bus transfers caused by this op
		int slot_cyc; // cycles from req until busy reads low
		n_xfer   = 1;
		op_valid <= 1'b1;
		op       <= kind;
		op_char  <= ch;
		case (kind)
			OP_CHAR: begin
				exp_q.push_back({1'b1, ch});
				line_fill++;
				if (line_fill == LINE_LEN) begin // cursor leaves this line
					n_xfer    = 2;
					line_fill = 0;
					on_line2  = !on_line2;
					exp_q.push_back({1'b0, CMD_SET_DDRAM | (on_line2 ? {1'b0, LINE2_ADDR} : 8'h00)});
				end
			end
			OP_CLEAR: begin
				exp_q.push_back({1'b0, CMD_CLEAR});
				line_fill = 0;
				on_line2  = 1'b0;
			end
			default: begin
				exp_q.push_back({1'b0, CMD_HOME});
				line_fill = 0;
				on_line2  = 1'b0;
			end
		endcase
		@(posedge clk);
		op_valid <= 1'b0;
		slot_cyc = 1;
		@(posedge clk);
		while (busy) begin
			@(posedge clk);
			slot_cyc++;
		end
		// each transfer takes one full slot, an address command follows back to back
		assert (slot_cyc == n_xfer * T_XFER_US * U)
			else value_mismatch("busy cycles", slot_cyc, n_xfer * T_XFER_US * U);
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		assert (cycles < TIMEOUT_CYC)
			else abort_run($sformatf("Timeout: the run did not end within %0d cycles", TIMEOUT_CYC));
	end

	always @(posedge clk) begin
		if (!rst && n_got < 4) begin
			assert (busy === 1'b1) else value_mismatch("busy", busy, 1);
		end
		if (got) begin
			assert (exp_q.size() > 0)
				else abort_run("A transfer appeared on the bus that the model did not expect");
			exp_x = exp_q.pop_front();
			exp_w = (n_got < 4) ? E_CMD_US * U : T_EHIGH_US * U;
			assert (got_width == exp_w) else value_mismatch("e high cycles", got_width, exp_w);
			assert (got_stable) else abort_run("rs, rw or lcd_data changed while e was high");
			assert (got_rs == exp_x[8]) else value_mismatch("rs", got_rs, exp_x[8]);
			assert (got_rw == 1'b0) else value_mismatch("rw", got_rw, 0);
			assert (got_data == exp_x[7:0]) else value_mismatch("lcd_data", got_data, exp_x[7:0]);
			n_got++;
		end
	end

	initial begin
		seed      = 32'hc2a5_7e7c;
		rnd       = $random(seed);
		cfg       = rnd[6:0];
		op_valid  = 1'b0;
		op        = OP_CHAR;
		op_char   = 8'h00;
		line_fill = 0;
		on_line2  = 1'b0;
		queue_init_cmds();
		@(posedge clk);
		while (rst) @(posedge clk);
		init_start = cycles;
		// pins quiet through the power-up wait
		repeat (POWER_CYC - 2) begin
			@(posedge clk);
			assert (e == 1'b0) else value_mismatch("e", e, 0);
			assert (rs == 1'b0) else value_mismatch("rs", rs, 0);
			assert (rw == 1'b0) else value_mismatch("rw", rw, 0);
			assert (lcd_data == 8'h00) else value_mismatch("lcd_data", lcd_data, 0);
		end
		while (busy) @(posedge clk);
		// power-up wait plus the four init commands and their waits
		assert (cycles - init_start == INIT_US * U)
			else value_mismatch("init cycles", cycles - init_start, INIT_US * U);
		assert (n_got == 4) else value_mismatch("init transfers", n_got, 4);
		for (int i = 0; i < N_OPS; i++) begin
			gap = {$random(seed)} % 6;
			repeat (gap) @(posedge clk);
			while (busy) @(posedge clk);
			pick = {$random(seed)} % 24;
			rnd  = {$random(seed)} % 95;
			if (pick == 0) begin
				issue_op(OP_CLEAR, 8'h00);
			end else if (pick == 1) begin
				issue_op(OP_HOME, 8'h00);
			end else begin
				issue_op(OP_CHAR, 8'h20 + rnd[7:0]); // printable ascii
			end
		end
		while (busy) @(posedge clk);
		repeat (4) @(posedge clk);
		if (exp_q.size() == 0) begin
			$display("TEST PASS");
			$finish;
		end else begin
			abort_run($sformatf("%0d expected transfers never appeared on the bus", exp_q.size()));
		end
	end

endmodule

//--- files.f
hdl/lcd_pkg.sv
hdl/lcd_bus_if.sv
hdl/lcd_ctrl.sv
hdl/lcd_text_writer.sv
hdl/lcd_top.sv
dv/lcd_clk_gen.sv
dv/lcd_bus_mon.sv
dv/lcd_tb.sv

//--- Bender.yml
package:
  name: lcd_text

sources:
  - hdl/lcd_pkg.sv
  - hdl/lcd_bus_if.sv
  - hdl/lcd_ctrl.sv
  - hdl/lcd_text_writer.sv
  - hdl/lcd_top.sv
  - target: simulation
    files:
      - dv/lcd_clk_gen.sv
      - dv/lcd_bus_mon.sv
      - dv/lcd_tb.sv
